// ==== tests/clock_vectors.txt ====
# Columns: op key count value. Keys 0 mode, 1 field, 2 step, 3 alarm; counts are decimal
# Values are hex: time as hhmmss, dp as a digit mask with digit 0 in bit 0, alarm as 0 or 1
alarm 0 0 0
press 0 1 0
time 0 0 000000
press 2 61 0
time 0 0 000001
press 1 2 0
press 2 25 0
time 0 0 010001
dp 0 0 01
press 2 22 0
press 1 2 0
press 2 59 0
press 1 2 0
press 2 57 0
time 0 0 235958
mark 0 0 0
press 0 2 0
run 0 3 0
press 0 1 0
time 0 0 000001
# Alarm mode shows the alarm time, the running time keeps counting
mark 0 0 0
press 0 1 0
press 2 5 0
time 0 0 000005
dp 0 0 02
press 0 1 0
dp 0 0 00
until 0 100 0
press 0 1 0
time 0 0 000141
# Time two seconds before the alarm, then let it trigger
press 2 22 0
press 1 1 0
press 2 59 0
press 1 2 0
time 0 0 000003
press 3 1 0
alarm 0 0 0
mark 0 0 0
press 0 2 0
alarm 0 0 0
run 0 3 0
alarm 0 0 1
press 3 1 0
alarm 0 0 0

// ==== src.f ====
design/clock_pkg.sv
design/tick_gen.sv
design/key_filter.sv
design/clock_ctrl.sv
design/time_keeper.sv
design/digit_scan.sv
design/clock_top.sv
tests/clock_properties.sv
tests/clock_tb.sv

// ==== Makefile ====
SRCS := $(shell cat src.f)

obj_dir/Vclock_tb: src.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module clock_tb -f src.f -o Vclock_tb

run: obj_dir/Vclock_tb tests/clock_vectors.txt
	./obj_dir/Vclock_tb > sim.log 2>&1 || true
	cat sim.log
	grep -q "ALL CHECKS PASSED" sim.log
	! grep -q "CHECKS FAILED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== tests/clock_tb.sv ====
// ----------------------------------------------------------
// Testbench for the wall clock top level. Reads operation
// lines from the vector file, presses keys, lets the clock
// run, decodes the scanned display and checks the results.
// ----------------------------------------------------------

module clock_tb import clock_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int unsigned TB_SEC_DIV = 2000;
	localparam int unsigned TB_KEY_DIV = 4;

	logic                  clk;
	logic                  rst_n;
	keys_t                 keys;
	seg_t                  seg;
	logic                  seg_dp;
	logic [NUM_DIGITS-1:0] seg_enb;
	logic                  alarm;

	// Cycles since reset release, and the last aligned mark
	longint unsigned cyc;
	longint unsigned mark_cyc;

	clock_top #(
		.SEC_DIV (TB_SEC_DIV),
		.KEY_DIV (TB_KEY_DIV)
	) dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_keys    (keys),
		.o_seg     (seg),
		.o_seg_dp  (seg_dp),
		.o_seg_enb (seg_enb),
		.o_alarm   (alarm)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		if (rst_n)
			cyc <= cyc + 1;
	end

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("CHECKS FAILED");
		$fatal(1, "stopping at first error");
	endtask

	// Failures of the bound assertions
	always @(negedge clk) begin
		if (dut.u_props.err_count != 0)
			fail_now("a bound assertion on the display or alarm outputs failed");
	end

	// ----------------------------------------------------------
	// Stimulus
	// ----------------------------------------------------------
	task automatic set_key(input int key, input logic level);
		case (key)
			0:       keys.mode_key  = level;
			1:       keys.field_key = level;
			2:       keys.step_key  = level;
			3:       keys.alarm_key = level;
			default: fail_now($sformatf("key number %0d does not exist", key));
		endcase
	endtask

	// Held and released for 12 key samples each
	task automatic press_key(input int key, input int count);
		repeat (count) begin
			set_key(key, 1'b1);
			repeat (12 * TB_KEY_DIV) @(posedge clk);
			#1;
			set_key(key, 1'b0);
			repeat (12 * TB_KEY_DIV) @(posedge clk);
			#1;
		end
	endtask

	task automatic run_seconds(input int secs);
		repeat (secs * TB_SEC_DIV) @(posedge clk);
		#1;
	endtask

	// Half way between two second ticks
	task automatic align_mid;
		int n;
		n = 0;
		while (cyc % TB_SEC_DIV != TB_SEC_DIV / 2) begin
			@(posedge clk);
			#1;
			n++;
			if (n > TB_SEC_DIV + 2)
				fail_now("timeout while aligning to the middle of a second");
		end
	endtask

	task automatic wait_until(input int secs);
		longint unsigned target;
		int n;
		target = mark_cyc + longint'(secs) * TB_SEC_DIV;
		if (cyc > target)
			fail_now("the marked number of seconds had passed before the wait began");
		n = 0;
		while (cyc < target) begin
			@(posedge clk);
			#1;
			n++;
			if (n > secs * TB_SEC_DIV + 2)
				fail_now("timeout while waiting for the marked time");
		end
	endtask

	// ----------------------------------------------------------
	// Display decoding
	// ----------------------------------------------------------
	function automatic int seg_to_digit(input seg_t s);
		int d;
		case (s)
			7'b111_1110: d = 0;
			7'b011_0000: d = 1;
			7'b110_1101: d = 2;
			7'b111_1001: d = 3;
			7'b011_0011: d = 4;
			7'b101_1011: d = 5;
			7'b101_1111: d = 6;
			7'b111_0000: d = 7;
			7'b111_1111: d = 8;
			7'b111_0011: d = 9;
			default:     d = -1;
		endcase
		return d;
	endfunction

	task automatic read_display(output hms_t t, output logic [NUM_DIGITS-1:0] dp);
		int digits [NUM_DIGITS];
		logic [NUM_DIGITS-1:0] code;
		int n;
		for (int d = 0; d < NUM_DIGITS; d++) begin
			code = ~(NUM_DIGITS'(1) << d);
			n = 0;
			@(negedge clk);
			while (seg_enb !== code) begin
				@(negedge clk);
				n++;
				if (n > (NUM_DIGITS + 1) * SCAN_DIV + 8)
					fail_now($sformatf("timeout waiting for the enable of digit %0d", d));
			end
			digits[d] = seg_to_digit(seg);
			if (digits[d] < 0)
				fail_now($sformatf("digit %0d shows no decimal digit pattern", d));
			dp[d] = seg_dp;
		end
		t.sec  = 6'(digits[1] * 10 + digits[0]);
		t.min  = 6'(digits[3] * 10 + digits[2]);
		t.hour = 5'(digits[5] * 10 + digits[4]);
		@(posedge clk);
		#1;
	endtask

	// Vector values are written as hhmmss
	function automatic hms_t bcd_to_hms(input logic [23:0] v);
		hms_t t;
		t.hour = 5'(v[23:20] * 10 + v[19:16]);
		t.min  = 6'(v[15:12] * 10 + v[11:8]);
		t.sec  = 6'(v[7:4] * 10 + v[3:0]);
		return t;
	endfunction

	// ----------------------------------------------------------
	// Compare tasks
	// ----------------------------------------------------------
	task automatic check_time(input string name, input hms_t exp, input hms_t act);
		if (exp !== act)
			fail_now($sformatf("FAILED %s: expected %02d:%02d:%02d, actual %02d:%02d:%02d",
				name, exp.hour, exp.min, exp.sec, act.hour, act.min, act.sec));
	endtask

	task automatic check_dp(input string name, input logic [NUM_DIGITS-1:0] exp,
		input logic [NUM_DIGITS-1:0] act);
		if (exp !== act)
			fail_now($sformatf("FAILED %s: expected %b, actual %b", name, exp, act));
	endtask

	task automatic check_alarm(input string name, input logic exp, input logic act);
		if (exp !== act)
			fail_now($sformatf("FAILED %s: expected %b, actual %b", name, exp, act));
	endtask

	initial begin
		int fd;
		int lineno;
		int n;
		int arg;
		int count;
		string line;
		string op;
		string name;
		logic [23:0] val;
		hms_t got_t;
		logic [NUM_DIGITS-1:0] got_dp;

		clk      = 1'b0;
		rst_n    = 1'b0;
		keys     = '0;
		cyc      = 0;
		mark_cyc = 0;
		lineno   = 0;

		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;

		fd = $fopen("tests/clock_vectors.txt", "r");
		if (fd == 0)
			fail_now("cannot open tests/clock_vectors.txt");

		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			lineno++;
			if (n == 0 || line.len() < 2 || line.getc(0) == "#")
				continue;
			n = $sscanf(line, "%s %d %d %h", op, arg, count, val);
			if (n != 4)
				fail_now($sformatf("vector line %0d is malformed", lineno));
			name = $sformatf("%s at line %0d", op, lineno);
			case (op)
				"press": press_key(arg, count);
				"run":   run_seconds(count);
				"mark": begin
					align_mid();
					mark_cyc = cyc;
				end
				"until": wait_until(count);
				"time": begin
					read_display(got_t, got_dp);
					check_time(name, bcd_to_hms(val), got_t);
				end
				"dp": begin
					read_display(got_t, got_dp);
					check_dp(name, val[NUM_DIGITS-1:0], got_dp);
				end
				"alarm": begin
					@(negedge clk);
					check_alarm(name, val[0], alarm);
					@(posedge clk);
					#1;
				end
				default: fail_now($sformatf("unknown operation on vector line %0d", lineno));
			endcase
		end
		$fclose(fd);

		if (dut.u_props.err_count != 0) begin
			fail_now("a bound assertion on the display or alarm outputs failed");
		end else begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

endmodule

// ==== tests/clock_properties.sv ====
// ----------------------------------------------------------
// Concurrent assertions on the display scan and the alarm
// output, bound into the wall clock top level. Failures are
// also counted so the testbench can end the run on them.
// ----------------------------------------------------------

module clock_properties import clock_pkg::*; (
	input logic                  clk,
	input logic                  rst_n,
	input logic [NUM_DIGITS-1:0] i_seg_enb,
	input logic                  i_seg_dp,
	input mode_t                 i_mode,
	input logic                  i_alarm,
	input logic                  i_alarm_en
);

	timeunit 1ns;
	timeprecision 100ps;

	// Number of assertion failures so far
	int unsigned err_count = 0;

	// Exactly one digit enabled
	enb_one_hot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot(~i_seg_enb))
		else begin
			$error("digit enable is not one-hot low");
			err_count++;
		end

	// Points only on digit 0 or digit 1, each for its own mode
	dp_place: assert property (@(posedge clk) disable iff (!rst_n)
		i_seg_dp |-> (!i_seg_enb[0] || !i_seg_enb[1]))
		else begin
			$error("decimal point lit on a digit other than 0 or 1");
			err_count++;
		end

	dp_setup: assert property (@(posedge clk) disable iff (!rst_n)
		(i_seg_dp && !i_seg_enb[0]) |-> (i_mode == MODE_SETUP))
		else begin
			$error("digit 0 point lit outside setup mode");
			err_count++;
		end

	dp_alarm: assert property (@(posedge clk) disable iff (!rst_n)
		(i_seg_dp && !i_seg_enb[1]) |-> (i_mode == MODE_ALARM))
		else begin
			$error("digit 1 point lit outside alarm mode");
			err_count++;
		end

	alarm_rise: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(i_alarm) |-> $past(i_alarm_en))
		else begin
			$error("alarm output rose while the alarm was disabled");
			err_count++;
		end

endmodule

bind clock_top clock_properties u_props (
	.clk        (clk),
	.rst_n      (rst_n),
	.i_seg_enb  (o_seg_enb),
	.i_seg_dp   (o_seg_dp),
	.i_mode     (mode),
	.i_alarm    (o_alarm),
	.i_alarm_en (alarm_en)
);

// ==== design/clock_top.sv ====
// ----------------------------------------------------------
// Wall clock top level. SEC_DIV and KEY_DIV set the clk
// cycles per second and per key sample, so a testbench can
// run the clock faster than real time.
// ----------------------------------------------------------

module clock_top import clock_pkg::*; #(
	parameter int unsigned SEC_DIV = SEC_DIV_DEFAULT,
	parameter int unsigned KEY_DIV = KEY_DIV_DEFAULT
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  keys_t                 i_keys,
	output seg_t                  o_seg,
	output logic                  o_seg_dp,
	output logic [NUM_DIGITS-1:0] o_seg_enb,
	output logic                  o_alarm
);

	logic  sec_tick;
	logic  key_tick;
	logic  scan_tick;
	keys_t press;
	mode_t mode;
	logic  alarm_en;
	step_t step;
	hms_t  disp;

	// Tick enables
	tick_gen #(.DIV(SEC_DIV)) u_sec_tick (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (sec_tick)
	);

	tick_gen #(.DIV(KEY_DIV)) u_key_tick (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (key_tick)
	);

	tick_gen #(.DIV(SCAN_DIV)) u_scan_tick (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (scan_tick)
	);

	key_filter u_key_filter (
		.clk      (clk),
		.rst_n    (rst_n),
		.i_sample (key_tick),
		.i_keys   (i_keys),
		.o_press  (press)
	);

	clock_ctrl u_clock_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_press    (press),
		.i_sec_tick (sec_tick),
		.o_mode     (mode),
		.o_alarm_en (alarm_en),
		.o_step     (step)
	);

	time_keeper u_time_keeper (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_step     (step),
		.i_mode     (mode),
		.i_alarm_en (alarm_en),
		.o_disp     (disp),
		.o_alarm    (o_alarm)
	);

	digit_scan u_digit_scan (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_scan    (scan_tick),
		.i_disp    (disp),
		.i_mode    (mode),
		.o_seg     (o_seg),
		.o_seg_dp  (o_seg_dp),
		.o_seg_enb (o_seg_enb)
	);

endmodule

// ==== design/digit_scan.sv ====
// ----------------------------------------------------------
// Six-digit display scanner. Splits the shown time into
// decimal digits, encodes them to segments and walks one
// active-low digit enable per scan tick, seconds first.
// ----------------------------------------------------------

module digit_scan import clock_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  i_scan,
	input  hms_t                  i_disp,
	input  mode_t                 i_mode,
	output seg_t                  o_seg,
	output logic                  o_seg_dp,
	output logic [NUM_DIGITS-1:0] o_seg_enb
);

	logic [$clog2(NUM_DIGITS)-1:0] idx;
	logic [3:0]                    digit [NUM_DIGITS];

	function automatic logic [3:0] tens(input logic [5:0] v);
		return 4'(v / 6'd10);
	endfunction

	function automatic logic [3:0] units(input logic [5:0] v);
		return 4'(v % 6'd10);
	endfunction

	// Digit 0 is the rightmost, seconds units
	always_comb begin
		digit[0] = units(i_disp.sec);
		digit[1] = tens(i_disp.sec);
		digit[2] = units(i_disp.min);
		digit[3] = tens(i_disp.min);
		digit[4] = units({1'b0, i_disp.hour});
		digit[5] = tens({1'b0, i_disp.hour});
	end

	// ----------------------------------------------------------
	// Scan counter
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			idx <= '0;
		end else if (i_scan) begin
			if (idx == ($clog2(NUM_DIGITS))'(NUM_DIGITS - 1))
				idx <= '0;
			else
				idx <= idx + 1'b1;
		end
	end

	assign o_seg     = SEG_PATTERN[digit[idx]];
	assign o_seg_enb = ~(NUM_DIGITS'(1) << idx);

	// Decimal points mark setup on digit 0, alarm on digit 1
	always_comb begin
		case (idx)
			3'd0:    o_seg_dp = (i_mode == MODE_SETUP);
			3'd1:    o_seg_dp = (i_mode == MODE_ALARM);
			default: o_seg_dp = 1'b0;
		endcase
	end

endmodule

// ==== design/time_keeper.sv ====
// ----------------------------------------------------------
// Running time and alarm time registers. Advances the time
// with carry on the run pulse, steps single fields without
// carry, selects the displayed time and latches the alarm.
// ----------------------------------------------------------

module time_keeper import clock_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  step_t i_step,
	input  mode_t i_mode,
	input  logic  i_alarm_en,
	output hms_t  o_disp,
	output logic  o_alarm
);

	hms_t tm;
	hms_t al;

	// Add one and wrap to zero after max
	function automatic logic [5:0] bump(input logic [5:0] v, input int unsigned max);
		return (v == 6'(max)) ? 6'd0 : v + 6'd1;
	endfunction

	// ----------------------------------------------------------
	// Running time
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tm <= '0;
		end else if (i_step.run) begin
			tm.sec <= bump(tm.sec, SEC_MAX);
			if (tm.sec == 6'(SEC_MAX)) begin
				tm.min <= bump(tm.min, MIN_MAX);
				if (tm.min == 6'(MIN_MAX)) begin
					tm.hour <= 5'(bump({1'b0, tm.hour}, HOUR_MAX));
				end
			end
		end else begin
			if (i_step.time_sec)
				tm.sec <= bump(tm.sec, SEC_MAX);
			if (i_step.time_min)
				tm.min <= bump(tm.min, MIN_MAX);
			if (i_step.time_hour)
				tm.hour <= 5'(bump({1'b0, tm.hour}, HOUR_MAX));
		end
	end

	// Alarm time only moves by field steps
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			al <= '0;
		end else begin
			if (i_step.alarm_sec)
				al.sec <= bump(al.sec, SEC_MAX);
			if (i_step.alarm_min)
				al.min <= bump(al.min, MIN_MAX);
			if (i_step.alarm_hour)
				al.hour <= 5'(bump({1'b0, al.hour}, HOUR_MAX));
		end
	end

	assign o_disp = (i_mode == MODE_ALARM) ? al : tm;

	// Match sets the level, dropping the enable clears it
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_alarm <= 1'b0;
		end else begin
			o_alarm <= i_alarm_en & (o_alarm | (tm == al));
		end
	end

endmodule

// ==== design/clock_ctrl.sv ====
// ----------------------------------------------------------
// Clock controller. Holds the mode, the selected field and
// the alarm enable, and turns key presses and the second
// tick into step pulses for the time and alarm registers.
// ----------------------------------------------------------

module clock_ctrl import clock_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  keys_t i_press,
	input  logic  i_sec_tick,
	output mode_t o_mode,
	output logic  o_alarm_en,
	output step_t o_step
);

	field_t field;

	// Mode cycles clock, setup, alarm
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_mode <= MODE_CLOCK;
		end else if (i_press.mode_key) begin
			case (o_mode)
				MODE_CLOCK: o_mode <= MODE_SETUP;
				MODE_SETUP: o_mode <= MODE_ALARM;
				default:    o_mode <= MODE_CLOCK;
			endcase
		end
	end

	// Field cycles sec, min, hour
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			field <= FIELD_SEC;
		end else if (i_press.field_key) begin
			case (field)
				FIELD_SEC: field <= FIELD_MIN;
				FIELD_MIN: field <= FIELD_HOUR;
				default:   field <= FIELD_SEC;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_alarm_en <= 1'b0;
		end else if (i_press.alarm_key) begin
			o_alarm_en <= ~o_alarm_en;
		end
	end

	// ----------------------------------------------------------
	// Step routing
	// ----------------------------------------------------------
	always_comb begin
		o_step     = '0;
		// Time stands still while it is being set
		o_step.run = i_sec_tick && (o_mode != MODE_SETUP);
		if (i_press.step_key) begin
			if (o_mode == MODE_SETUP) begin
				o_step.time_sec  = (field == FIELD_SEC);
				o_step.time_min  = (field == FIELD_MIN);
				o_step.time_hour = (field == FIELD_HOUR);
			end else if (o_mode == MODE_ALARM) begin
				o_step.alarm_sec  = (field == FIELD_SEC);
				o_step.alarm_min  = (field == FIELD_MIN);
				o_step.alarm_hour = (field == FIELD_HOUR);
			end
		end
	end

endmodule

// ==== design/key_filter.sv ====
// ----------------------------------------------------------
// Key input filter. Synchronizes the four key levels,
// debounces them at the key sample tick and emits a
// one-cycle press pulse per key on each debounced rise.
// ----------------------------------------------------------

module key_filter import clock_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  i_sample,
	input  keys_t i_keys,
	output keys_t o_press
);

	keys_t sync1;
	keys_t sync2;
	keys_t samp;
	keys_t deb;
	keys_t deb_d;

	// Two-flop synchronizer
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync1 <= '0;
			sync2 <= '0;
		end else begin
			sync1 <= i_keys;
			sync2 <= sync1;
		end
	end

	// Two equal samples in a row change the debounced level
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			samp <= '0;
			deb  <= '0;
		end else if (i_sample) begin
			samp <= sync2;
			deb  <= (deb | (sync2 & samp)) & (sync2 | samp);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			deb_d <= '0;
		end else begin
			deb_d <= deb;
		end
	end

	assign o_press = deb & ~deb_d;

endmodule

// ==== design/tick_gen.sv ====
// ----------------------------------------------------------
// Tick enable generator. Pulses o_tick for one clk cycle
// every DIV cycles, the first one DIV cycles after reset.
// ----------------------------------------------------------

module tick_gen #(
	parameter int unsigned DIV = 5000
) (
	input  logic clk,
	input  logic rst_n,
	output logic o_tick
);

	logic [$clog2(DIV)-1:0] cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt    <= '0;
			o_tick <= 1'b0;
		end else if (cnt == ($clog2(DIV))'(DIV - 1)) begin
			cnt    <= '0;
			o_tick <= 1'b1;
		end else begin
			cnt    <= cnt + 1'b1;
			o_tick <= 1'b0;
		end
	end

endmodule

// ==== design/clock_pkg.sv ====
// ----------------------------------------------------------
// Shared constants, encodings and packed types for the
// wall clock with alarm. Every design module imports it
// through a wildcard import in its module header.
// ----------------------------------------------------------

package clock_pkg;

	// Last value of each time field
	localparam int unsigned SEC_MAX  = 59;
	localparam int unsigned MIN_MAX  = 59;
	localparam int unsigned HOUR_MAX = 23;

	// Divisors for a 50 MHz clk
	localparam int unsigned SEC_DIV_DEFAULT = 50_000_000;
	localparam int unsigned KEY_DIV_DEFAULT = 500_000;
	localparam int unsigned SCAN_DIV        = 5000;

	localparam int unsigned NUM_DIGITS = 6;

	typedef enum logic [1:0] {
		MODE_CLOCK = 2'd0,
		MODE_SETUP = 2'd1,
		MODE_ALARM = 2'd2
	} mode_t;

	typedef enum logic [1:0] {
		FIELD_SEC  = 2'd0,
		FIELD_MIN  = 2'd1,
		FIELD_HOUR = 2'd2
	} field_t;

	typedef struct packed {
		logic [4:0] hour;
		logic [5:0] min;
		logic [5:0] sec;
	} hms_t;

	typedef struct packed {
		logic mode_key;
		logic field_key;
		logic step_key;
		logic alarm_key;
	} keys_t;

	// One-cycle pulses into the time and alarm registers
	typedef struct packed {
		logic time_sec;
		logic time_min;
		logic time_hour;
		logic alarm_sec;
		logic alarm_min;
		logic alarm_hour;
		logic run;
	} step_t;

	// Bit 6 is segment a, bit 0 is segment g, active high
	typedef logic [6:0] seg_t;

	localparam seg_t SEG_PATTERN [10] = '{
		7'b111_1110,
		7'b011_0000,
		7'b110_1101,
		7'b111_1001,
		7'b011_0011,
		7'b101_1011,
		7'b101_1111,
		7'b111_0000,
		7'b111_1111,
		7'b111_0011
	};

endpackage
